// ==== vlog.f ====
source/i2c_standby_pkg.sv
source/i2c_line_filter.sv
source/i2c_target_fsm.sv
source/flow_standby_i2c.sv
source/controller_standby_i2c.sv
bench/tb_controller_standby_i2c.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_controller_standby_i2c
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_controller_standby_i2c.sv ====
// Host model runs SCL at 64 clocks per bit and checks RX words, descriptors and ACK slots
`timescale 1ns/1ps

module tb_controller_standby_i2c
  import i2c_standby_pkg::*;
;

  localparam int QuarterCycles = 16;
  localparam int BitCycles = 4 * QuarterCycles;
  localparam int MaxBytes = 8;
  localparam int NumRows = 7;
  // Every row fits in 9 byte slots of 9 bits plus start, end and drain time
  localparam int CycleLimit =
    NumRows * ((MaxBytes + 1) * 9 * BitCycles + 12 * QuarterCycles) + 100;
  localparam logic [6:0] ExpTargetAddr = 7'h0C;

  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] count;
    logic       restart;
    logic       en;
  } row_t;

  localparam row_t Rows [NumRows] = '{
    '{addr: 8'h18, count: 8'd5, restart: 1'b0, en: 1'b1},
    '{addr: 8'h18, count: 8'd8, restart: 1'b0, en: 1'b1},
    '{addr: 8'h2A, count: 8'd2, restart: 1'b0, en: 1'b1},
    '{addr: 8'h19, count: 8'd0, restart: 1'b0, en: 1'b1},
    '{addr: 8'h18, count: 8'd3, restart: 1'b1, en: 1'b1},
    '{addr: 8'h18, count: 8'd6, restart: 1'b0, en: 1'b1},
    '{addr: 8'h18, count: 8'd3, restart: 1'b0, en: 1'b0}
  };

  logic                   clk;
  logic                   arst_n;
  logic                   scl_host;
  logic                   sda_host;
  logic                   standby_en;
  logic [HoldWidth-1:0]   t_hd_dat;
  logic                   bus_sda;
  logic                   ctrl_sda;
  logic                   rx_wvalid;
  logic [RxDataWidth-1:0] rx_wdata;
  logic                   desc_wvalid;
  logic [RxDescWidth-1:0] desc_wdata;
  logic [7:0]             bus_addr;
  logic                   bus_addr_valid;
  logic [31:0]            rnd;
  logic                   prev_restart;
  int                     cycle_cnt = 0;

  logic [31:0] got_words [$];
  logic [31:0] got_descs [$];
  logic [31:0] got_addrs [$];
  logic [31:0] exp_words [$];
  logic [31:0] exp_descs [$];
  logic [31:0] exp_addrs [$];

  // Open-drain bus where either side can pull SDA low
  assign bus_sda = sda_host & ctrl_sda;

  controller_standby_i2c u_controller_standby_i2c (
    .clk_i                  (clk),
    .arst_n_i               (arst_n),
    .ctrl_scl_i             (scl_host),
    .ctrl_sda_i             (bus_sda),
    .i2c_standby_en_i       (standby_en),
    .t_hd_dat_i             (t_hd_dat),
    .ctrl_sda_o             (ctrl_sda),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_queue_wvalid_o (desc_wvalid),
    .rx_desc_queue_wdata_o  (desc_wdata),
    .bus_addr_o             (bus_addr),
    .bus_addr_valid_o       (bus_addr_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Strobes are captured mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rx_wvalid) begin
      got_words.push_back(rx_wdata);
    end
    if (desc_wvalid) begin
      got_descs.push_back(desc_wdata);
    end
    if (bus_addr_valid) begin
      got_addrs.push_back({24'h0, bus_addr});
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CycleLimit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CycleLimit);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One SCL period with SDA set while SCL is low and sampled mid-high
  task automatic clock_bit(input logic b, output logic seen);
    wait_cycles(QuarterCycles);
    sda_host <= b;
    wait_cycles(QuarterCycles);
    scl_host <= 1'b1;
    wait_cycles(QuarterCycles);
    @(negedge clk);
    seen = bus_sda;
    wait_cycles(QuarterCycles);
    scl_host <= 1'b0;
  endtask

  task automatic transfer_byte(input logic [7:0] b, output logic acked);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], seen);
      // Target keeps SDA released while the host sends
      check_value("SDA bit", {31'h0, seen}, {31'h0, b[i]});
    end
    // Host releases SDA for the ACK slot
    clock_bit(1'b1, seen);
    acked = !seen;
  endtask

  task automatic issue_start();
    wait_cycles(QuarterCycles);
    sda_host <= 1'b0;
    wait_cycles(QuarterCycles);
    scl_host <= 1'b0;
  endtask

  // Both end conditions leave SCL where the next phase expects it
  task automatic end_transfer(input logic restart);
    wait_cycles(QuarterCycles);
    sda_host <= restart;
    wait_cycles(QuarterCycles);
    scl_host <= 1'b1;
    wait_cycles(QuarterCycles);
    sda_host <= !restart;
    wait_cycles(QuarterCycles);
    if (restart) begin
      scl_host <= 1'b0;
    end
  endtask

  task automatic run_row(input row_t row, input logic skip_start);
    logic [7:0]  data [$];
    logic [31:0] word;
    logic        exp_ack;
    logic        acked;
    wait_cycles(1);
    standby_en <= row.en;
    exp_ack = row.en && (row.addr[7:1] == ExpTargetAddr) && !row.addr[0];
    if (row.addr[7:1] == ExpTargetAddr) begin
      exp_addrs.push_back({24'h0, row.addr});
    end
    word = '0;
    for (int k = 0; k < int'(row.count); k++) begin
      rnd = $urandom();
      data.push_back(rnd[7:0]);
      word[8*(k%4) +: 8] = rnd[7:0];
      if (exp_ack && (k % 4 == 3)) begin
        exp_words.push_back(word);
        word = '0;
      end
    end
    if (exp_ack) begin
      if (row.count % 4 != 0) begin
        exp_words.push_back(word);
      end
      exp_descs.push_back({15'h0, row.restart, 8'h0, row.count});
    end
    if (!skip_start) begin
      issue_start();
    end
    transfer_byte(row.addr, acked);
    check_value("address ACK", {31'h0, acked}, {31'h0, exp_ack});
    foreach (data[k]) begin
      transfer_byte(data[k], acked);
      check_value("data ACK", {31'h0, acked}, {31'h0, exp_ack});
    end
    end_transfer(row.restart);
    while (got_descs.size() < exp_descs.size()) begin
      @(posedge clk);
    end
  endtask

  task automatic compare_queues();
    check_value("bus_addr strobe count", got_addrs.size(), exp_addrs.size());
    foreach (exp_addrs[i]) begin
      check_value("bus_addr byte", got_addrs[i], exp_addrs[i]);
    end
    check_value("RX word count", got_words.size(), exp_words.size());
    foreach (exp_words[i]) begin
      check_value("RX word", got_words[i], exp_words[i]);
    end
    check_value("descriptor count", got_descs.size(), exp_descs.size());
    foreach (exp_descs[i]) begin
      check_value("descriptor", got_descs[i], exp_descs[i]);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    scl_host = 1'b1;
    sda_host = 1'b1;
    standby_en = 1'b0;
    t_hd_dat = HoldWidth'(4);
    prev_restart = 1'b0;
    rnd = $urandom(26);
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    wait_cycles(4);
    for (int r = 0; r < NumRows; r++) begin
      run_row(Rows[r], prev_restart);
      prev_restart = Rows[r].restart;
    end
    compare_queues();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== source/controller_standby_i2c.sv ====
// Open-drain SDA only with no SCL drive. The TTI queue owner takes every strobe
`timescale 1ns/1ps

module controller_standby_i2c
  import i2c_standby_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   ctrl_scl_i,
  input  logic                   ctrl_sda_i,
  input  logic                   i2c_standby_en_i,
  input  logic [HoldWidth-1:0]   t_hd_dat_i,
  output logic                   ctrl_sda_o,
  output logic                   rx_queue_wvalid_o,
  output logic [RxDataWidth-1:0] rx_queue_wdata_o,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0] rx_desc_queue_wdata_o,
  output logic [7:0]             bus_addr_o,
  output logic                   bus_addr_valid_o
);

  // Bit 0 carries SCL and bit 1 carries SDA
  logic [1:0] pad_raw;
  logic [1:0] pad_filt;
  logic       scl_filt;
  logic       sda_filt;
  logic       acq_valid;
  acq_op_e    acq_op;
  logic [7:0] acq_data;

  assign pad_raw  = {ctrl_sda_i, ctrl_scl_i};
  assign scl_filt = pad_filt[0];
  assign sda_filt = pad_filt[1];

  for (genvar g = 0; g < 2; g++) begin : g_line_filter
    i2c_line_filter u_i2c_line_filter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .line_i   (pad_raw[g]),
      .line_o   (pad_filt[g])
    );
  end

  i2c_target_fsm u_i2c_target_fsm (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .scl_i            (scl_filt),
    .sda_i            (sda_filt),
    .target_enable_i  (i2c_standby_en_i),
    .t_hd_dat_i       (t_hd_dat_i),
    .sda_o            (ctrl_sda_o),
    .acq_valid_o      (acq_valid),
    .acq_op_o         (acq_op),
    .acq_data_o       (acq_data),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o)
  );

  flow_standby_i2c u_flow_standby_i2c (
    .clk_i                  (clk_i),
    .arst_n_i               (arst_n_i),
    .acq_valid_i            (acq_valid),
    .acq_op_i               (acq_op),
    .acq_data_i             (acq_data),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o)
  );

endmodule

// ==== source/flow_standby_i2c.sv ====
// Queue strobes have no back-pressure so the consumer must accept every write
`timescale 1ns/1ps

module flow_standby_i2c
  import i2c_standby_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   acq_valid_i,
  input  acq_op_e                acq_op_i,
  input  logic [7:0]             acq_data_i,
  output logic                   rx_queue_wvalid_o,
  output logic [RxDataWidth-1:0] rx_queue_wdata_o,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0] rx_desc_queue_wdata_o
);

  logic [RxDataWidth-1:0]    word_q;
  logic [RxDataWidth-1:0]    flush_word;
  logic [RxDescWidth-1:0]    desc_d;
  logic [LaneWidth-1:0]      lane_q;
  logic [DescCountWidth-1:0] count_q;
  logic                      desc_pend_q;
  logic                      last_lane;

  assign last_lane = (lane_q == LaneWidth'(BytesPerWord - 1));

  // Partial word with lanes not yet written forced to zero
  always_comb begin
    flush_word = '0;
    for (int i = 0; i < BytesPerWord; i++) begin
      if (i < lane_q) begin
        flush_word[8*i +: 8] = word_q[8*i +: 8];
      end
    end
  end

  always_comb begin
    desc_d                       = '0;
    desc_d[DescCountWidth-1:0]   = count_q;
    desc_d[DescRestartBit]       = (acq_op_i == ACQ_RESTART);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q                 <= '0;
      count_q                <= '0;
      desc_pend_q            <= 1'b0;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= desc_pend_q;
      desc_pend_q            <= 1'b0;

      if (acq_valid_i) begin
        if (acq_op_i == ACQ_DATA) begin
          lane_q  <= lane_q + 1'b1;
          count_q <= count_q + 1'b1;
          if (last_lane) begin
            rx_queue_wvalid_o <= 1'b1;
          end
        end else begin
          lane_q  <= '0;
          count_q <= '0;
          // Descriptor waits one cycle behind a flushed partial word
          if (lane_q != '0) begin
            rx_queue_wvalid_o <= 1'b1;
            desc_pend_q       <= 1'b1;
          end else begin
            rx_desc_queue_wvalid_o <= 1'b1;
          end
        end
      end
    end
  end

  // Little-endian packing, first byte of the word in bits 7:0
  always_ff @(posedge clk_i) begin
    if (acq_valid_i) begin
      if (acq_op_i == ACQ_DATA) begin
        word_q[{lane_q, 3'b000} +: 8] <= acq_data_i;
        if (last_lane) begin
          rx_queue_wdata_o <= {acq_data_i, word_q[RxDataWidth-9:0]};
        end
      end else begin
        rx_queue_wdata_o      <= flush_word;
        rx_desc_queue_wdata_o <= desc_d;
      end
    end
  end

endmodule

// ==== source/i2c_target_fsm.sv ====
// Write-only target with no clock stretching. Read addresses are reported but NACKed
`timescale 1ns/1ps

module i2c_target_fsm
  import i2c_standby_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 scl_i,
  input  logic                 sda_i,
  input  logic                 target_enable_i,
  input  logic [HoldWidth-1:0] t_hd_dat_i,
  output logic                 sda_o,
  output logic                 acq_valid_o,
  output acq_op_e              acq_op_o,
  output logic [7:0]           acq_data_o,
  output logic [7:0]           bus_addr_o,
  output logic                 bus_addr_valid_o
);

  fsm_state_e           state_q;
  logic                 scl_q;
  logic                 sda_q;
  logic [3:0]           bit_cnt_q;
  logic [7:0]           byte_q;
  logic [7:0]           byte_next;
  logic                 xfer_active_q;
  logic                 hold_active_q;
  logic [HoldWidth-1:0] hold_cnt_q;
  logic                 sda_pend_q;
  logic                 scl_rise;
  logic                 scl_fall;
  logic                 start_det;
  logic                 stop_det;
  logic                 shifting;
  logic                 byte_fall;
  logic                 addr_hit;
  logic                 addr_ok;

  assign scl_rise  = scl_i & ~scl_q;
  assign scl_fall  = ~scl_i & scl_q;
  // START and STOP are SDA edges while SCL stays high
  assign start_det = scl_i & scl_q & sda_q & ~sda_i;
  assign stop_det  = scl_i & scl_q & ~sda_q & sda_i;

  assign shifting  = scl_rise && (state_q == ADDR || state_q == DATA);
  assign byte_next = {byte_q[6:0], sda_i};
  assign byte_fall = scl_fall && (bit_cnt_q == 4'd8);

  // Match on the byte being completed, RnW ignored
  assign addr_hit  = (byte_next[7:1] == TargetAddr);
  // Full byte already shifted in when the 8th falling edge arrives
  assign addr_ok   = target_enable_i && (byte_q[7:1] == TargetAddr) && !byte_q[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q          <= IDLE;
      scl_q            <= 1'b1;
      sda_q            <= 1'b1;
      bit_cnt_q        <= '0;
      xfer_active_q    <= 1'b0;
      hold_active_q    <= 1'b0;
      hold_cnt_q       <= '0;
      sda_pend_q       <= 1'b1;
      sda_o            <= 1'b1;
      acq_valid_o      <= 1'b0;
      acq_op_o         <= ACQ_DATA;
      bus_addr_valid_o <= 1'b0;
    end else begin
      scl_q            <= scl_i;
      sda_q            <= sda_i;
      acq_valid_o      <= 1'b0;
      bus_addr_valid_o <= 1'b0;

      // Apply the pending SDA level once the data hold time has elapsed
      if (hold_active_q) begin
        if (hold_cnt_q == '0) begin
          sda_o         <= sda_pend_q;
          hold_active_q <= 1'b0;
        end else begin
          hold_cnt_q <= hold_cnt_q - 1'b1;
        end
      end

      if (start_det || stop_det) begin
        // Close the transfer only if its address was ACKed
        if (xfer_active_q) begin
          acq_valid_o <= 1'b1;
          acq_op_o    <= stop_det ? ACQ_STOP : ACQ_RESTART;
        end
        xfer_active_q <= 1'b0;
        hold_active_q <= 1'b0;
        sda_o         <= 1'b1;
        bit_cnt_q     <= '0;
        state_q       <= start_det ? ADDR : IDLE;
      end else begin
        unique case (state_q)
          ADDR, DATA: begin
            if (scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 4'd7) begin
                if (state_q == ADDR) begin
                  bus_addr_valid_o <= addr_hit;
                end else begin
                  acq_valid_o <= 1'b1;
                  acq_op_o    <= ACQ_DATA;
                end
              end
            end else if (byte_fall) begin
              hold_active_q <= 1'b1;
              hold_cnt_q    <= t_hd_dat_i;
              if (state_q == ADDR) begin
                xfer_active_q <= addr_ok;
                sda_pend_q    <= ~addr_ok;
                state_q       <= ADDR_ACK;
              end else begin
                sda_pend_q <= 1'b0;
                state_q    <= DATA_ACK;
              end
            end
          end
          ADDR_ACK, DATA_ACK: begin
            // 9th falling edge ends the ACK slot
            if (scl_fall) begin
              hold_active_q <= 1'b1;
              hold_cnt_q    <= t_hd_dat_i;
              sda_pend_q    <= 1'b1;
              bit_cnt_q     <= '0;
              state_q       <= xfer_active_q ? DATA : IGNORE;
            end
          end
          IDLE, IGNORE: begin
            // Only START or STOP leaves these states
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // Shift register and captured bytes
  always_ff @(posedge clk_i) begin
    if (shifting) begin
      byte_q <= byte_next;
      if (bit_cnt_q == 4'd7) begin
        if (state_q == ADDR) begin
          bus_addr_o <= byte_next;
        end else begin
          acq_data_o <= byte_next;
        end
      end
    end
  end

endmodule

// ==== source/i2c_line_filter.sv ====
// Output lags a settled pad by 2 + FilterLen clocks and idles high after reset
`timescale 1ns/1ps

module i2c_line_filter
  import i2c_standby_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic line_i,
  output logic line_o
);

  // Two-flop resynchronizer, oldest sample in bit 1
  logic [1:0] sync_q;

  // Run length of samples that differ from the current output
  logic [FilterCntWidth-1:0] stable_cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q       <= 2'b11;
      stable_cnt_q <= '0;
      line_o       <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], line_i};

      if (sync_q[1] == line_o) begin
        // Glitch ended or line agrees, start over
        stable_cnt_q <= '0;
      end else if (stable_cnt_q == FilterCntWidth'(FilterLen - 1)) begin
        line_o       <= sync_q[1];
        stable_cnt_q <= '0;
      end else begin
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== source/i2c_standby_pkg.sv ====
// Target address is fixed at 0x0C and only write transfers are supported
package i2c_standby_pkg;

  // Address this target answers on the bus
  localparam logic [6:0] TargetAddr = 7'h0C;

  // Line filter depth in synchronized samples
  localparam int FilterLen = 3;
  localparam int FilterCntWidth = $clog2(FilterLen + 1);

  // TTI queue word widths
  localparam int RxDataWidth = 32;
  localparam int RxDescWidth = 32;

  // Byte lanes in one RX data word
  localparam int BytesPerWord = RxDataWidth / 8;
  localparam int LaneWidth = $clog2(BytesPerWord);

  // RX descriptor fields
  localparam int DescCountWidth = 16;
  localparam int DescRestartBit = 16;

  // Data hold timer width
  localparam int HoldWidth = 20;

  // Acquisition stream opcodes from the FSM to the flow block
  typedef enum logic [1:0] {
    ACQ_DATA    = 2'd0,
    ACQ_STOP    = 2'd1,
    ACQ_RESTART = 2'd2
  } acq_op_e;

  // Bit-level target FSM states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    ADDR     = 3'd1,
    ADDR_ACK = 3'd2,
    DATA     = 3'd3,
    DATA_ACK = 3'd4,
    IGNORE   = 3'd5
  } fsm_state_e;

endpackage
